//--- all.f
+incdir+include
verilog/rvPkg.sv
verilog/instrDecoder.sv
verilog/registerFile.sv
verilog/aluStage.sv
verilog/rvCore.sv
bench/wbChecker.sv
bench/rvCoreTb.sv

//--- bench/rvCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvCore_cfg.svh"

module rvCoreTb;
  import rvPkg::*;

  localparam int stimLines     = 32;
  localparam int stimCols      = 5;   // instr, kind, rd, data, gap
  localparam int clkPeriod     = 100;
  localparam int timeoutCycles = stimLines * 4 + 20;

  logic                   clk        = 1'b0;
  logic                   rst        = 1'b1;
  logic                   instrValid = 1'b0;
  logic [`XLEN-1:0]       instr      = '0;
  wbT                     wb;
  logic                   illegal;

  logic [31:0]            stimRaw [stimLines*stimCols];
  logic [`XLEN-1:0]       instrMem [stimLines];
  logic [2:0]             gapMem [stimLines];   // 3 means random gap
  logic [1:0]             expKind [stimLines];
  logic [`REG_ADDR_W-1:0] expRd [stimLines];
  logic [`XLEN-1:0]       expData [stimLines];

  int                     checks;
  int                     mismatches;
  int                     otherErrors;
  logic                   allSeen;

  always #(clkPeriod/2) clk = ~clk;

  rvCore UUT (
    .clk          (clk),
    .rst          (rst),
    .instrValid_i (instrValid),
    .instr_i      (instr),
    .wb_o         (wb),
    .illegal_o    (illegal)
  );

  wbChecker #(.numLines(stimLines)) wbCheck (
    .clk           (clk),
    .rst           (rst),
    .wb_i          (wb),
    .illegal_i     (illegal),
    .expKind_i     (expKind),
    .expRd_i       (expRd),
    .expData_i     (expData),
    .checks_o      (checks),
    .mismatches_o  (mismatches),
    .otherErrors_o (otherErrors),
    .allSeen_o     (allSeen)
  );

  // ======================================================================
  // Stimulus file and summary
  // ======================================================================

  task automatic loadStimulus();
    $readmemh("bench/rvCore_stim.txt", stimRaw);
    for (int i = 0; i < stimLines; i++) begin
      instrMem[i] = stimRaw[i*stimCols];
      expKind[i]  = stimRaw[i*stimCols+1][1:0];
      expRd[i]    = stimRaw[i*stimCols+2][`REG_ADDR_W-1:0];
      expData[i]  = stimRaw[i*stimCols+3];
      gapMem[i]   = stimRaw[i*stimCols+4][2:0];
    end
  endtask

  task automatic reportCounts();
    $display("Checked %0d results: %0d mismatches, %0d other errors",
             checks, mismatches, otherErrors);
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================

  initial begin
    int gap;
    void'($urandom(5));
    loadStimulus();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < stimLines; i++) begin
      gap = (gapMem[i] > 3'd2) ? int'($urandom % 3) : int'(gapMem[i]);
      repeat (gap) begin
        @(posedge clk);
        instrValid <= 1'b0;
      end
      @(posedge clk);
      instrValid <= 1'b1;
      instr      <= instrMem[i];
    end
    @(posedge clk);
    instrValid <= 1'b0;
    wait (allSeen);
    repeat (4) @(posedge clk);   // Room for stray pulses
    reportCounts();
    if (mismatches == 0 && otherErrors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (timeoutCycles) @(posedge clk);
    $display("Timeout: not every expected result appeared within %0d cycles",
             timeoutCycles);
    reportCounts();
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/rvCore_stim.txt
// instr    kind(0 none, 1 write, 2 illegal)  rd  data
// last column is the idle gap before the instruction (0 to 2 fixed, 3 random)
00500093 1 01 00000005 3
FFD00113 1 02 FFFFFFFD 3
7FF00193 1 03 000007FF 3
80000237 1 04 80000000 3
002082B3 1 05 00000002 3
40208333 1 06 00000008 3
001123B3 1 07 00000001 3
00113433 1 08 00000000 3
0030C4B3 1 09 000007FA 3
00125533 1 0A 04000000 3
401255B3 1 0B FC000000 3
0040E633 1 0C 80000005 3
0021F6B3 1 0D 000007FD 3
00309733 1 0E 80000000 3
FFE12793 1 0F 00000001 3
FFF0B813 1 10 00000001 3
FFF24893 1 11 7FFFFFFF 3
0F00E913 1 12 000000F5 3
0FF17993 1 13 000000FD 3
00409A13 1 14 00000050 3
00825A93 1 15 00800000 3
40825B13 1 16 FF800000 3
00A08B93 1 17 0000000F 3
017B8C33 1 18 0000001E 0
401C0CB3 1 19 00000019 1
06408013 0 00 00000000 3
00100DB3 1 1B 00000005 0
00208463 2 00 00000000 3
0000AE83 2 00 00000000 0
FFFFFFFF 2 00 00000000 0
02208F33 2 00 00000000 1
001F0FB3 1 1F 00000005 0

//--- bench/wbChecker.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvCore_cfg.svh"

module wbChecker #(
  parameter int numLines = 1
) (
  input  logic                   clk,
  input  logic                   rst,
  input  rvPkg::wbT              wb_i,
  input  logic                   illegal_i,
  input  logic [1:0]             expKind_i [numLines],
  input  logic [`REG_ADDR_W-1:0] expRd_i [numLines],
  input  logic [`XLEN-1:0]       expData_i [numLines],
  output int                     checks_o,
  output int                     mismatches_o,
  output int                     otherErrors_o,
  output logic                   allSeen_o
);

  localparam logic [1:0] kindNone    = 2'd0;   // Legal, rd is x0
  localparam logic [1:0] kindWrite   = 2'd1;
  localparam logic [1:0] kindIllegal = 2'd2;

  int   idx         = 0;   // Next expected entry
  int   checks      = 0;
  int   mismatches  = 0;
  int   otherErrors = 0;
  logic allSeen     = 1'b0;

  assign checks_o      = checks;
  assign mismatches_o  = mismatches;
  assign otherErrors_o = otherErrors;
  assign allSeen_o     = allSeen;

  // Entries that must leave no trace on the outputs
  task automatic skipSilentEntries();
    while (idx < numLines && expKind_i[idx] == kindNone) begin
      idx++;
    end
  endtask

  task automatic checkWriteback();
    if (idx >= numLines) begin
      $display("Unexpected writeback to x%0d after the last expected result", wb_i.rd);
      otherErrors++;
    end else if (expKind_i[idx] != kindWrite) begin
      $display("Writeback to x%0d seen where entry %0d expects an illegal pulse",
               wb_i.rd, idx);
      otherErrors++;
      idx++;
    end else begin
      if (wb_i.rd !== expRd_i[idx]) begin
        $display("mismatch wb_o.rd (entry %0d): expected 0x%h, got 0x%h",
                 idx, expRd_i[idx], wb_i.rd);
        mismatches++;
      end
      if (wb_i.data !== expData_i[idx]) begin
        $display("mismatch wb_o.data (entry %0d): expected 0x%h, got 0x%h",
                 idx, expData_i[idx], wb_i.data);
        mismatches++;
      end
      checks++;
      idx++;
    end
  endtask

  task automatic checkIllegal();
    if (idx >= numLines) begin
      $display("Unexpected illegal pulse after the last expected result");
      otherErrors++;
    end else if (expKind_i[idx] != kindIllegal) begin
      $display("Illegal pulse seen where entry %0d expects a writeback", idx);
      otherErrors++;
      idx++;
    end else begin
      checks++;
      idx++;
    end
  endtask

  // Outputs change on the rising edge, so look at them mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      skipSilentEntries();
      if (wb_i.valid) begin
        checkWriteback();
      end
      if (illegal_i) begin
        checkIllegal();
      end
      skipSilentEntries();
      allSeen = (idx >= numLines);
    end
  end

endmodule

`default_nettype wire

//--- include/rvCore_cfg.svh
`ifndef RVCORE_CFG_SVH
`define RVCORE_CFG_SVH

// ======================================================================
// Datapath and register file sizing
// ======================================================================

`define XLEN        32   // Integer register and ALU width
`define REG_COUNT   32   // x0..x31
`define REG_ADDR_W  5    // Register index width

// ======================================================================
// RV32I major opcode field values, instr[6:0]
// ======================================================================

`define OPC_OP      7'b0110011   // Register-register ALU ops
`define OPC_OP_IMM  7'b0010011   // Register-immediate ALU ops
`define OPC_LUI     7'b0110111   // Load upper immediate

// Funct7 values that select the alternate ALU op
`define FUNCT7_BASE 7'b0000000
`define FUNCT7_ALT  7'b0100000   // SUB and SRA/SRAI

`endif

//--- run.sh
#!/bin/sh
# Build and run the rvCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module rvCoreTb -f all.f -o rvCoreSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rvCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation run exited with status $status"
  exit 1
fi

if grep -qx "Simulation completed successfully" sim.log; then
  exit 0
fi
exit 1

//--- verilog/aluStage.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvCore_cfg.svh"

module aluStage (
  input  logic           clk,
  input  logic           rst,
  input  rvPkg::decodedT dec_i,
  output rvPkg::wbT      wb_o,
  output logic           illegal_o
);
  import rvPkg::*;

  logic [`XLEN-1:0] opA;
  logic [`XLEN-1:0] rs2Fwd;
  logic [`XLEN-1:0] opB;
  logic [4:0]       shamt;
  logic [`XLEN-1:0] result;

  // ======================================================================
  // Operand forwarding
  // ======================================================================

  // Producer issued one cycle earlier is still sitting in wb_o
  assign opA = (wb_o.valid && wb_o.rd == dec_i.rs1) ? wb_o.data : dec_i.rs1Val;
  assign rs2Fwd = (wb_o.valid && wb_o.rd == dec_i.rs2) ? wb_o.data : dec_i.rs2Val;

  assign opB   = dec_i.useImm ? dec_i.imm : rs2Fwd;
  assign shamt = opB[4:0];   // RV32I shifts use low five bits

  // ======================================================================
  // ALU
  // ======================================================================

  always_comb begin
    case (dec_i.aluOp)
      AluAdd:   result = opA + opB;
      AluSub:   result = opA - opB;
      AluSll:   result = opA << shamt;
      AluSlt:   result = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
      AluSltu:  result = {{(`XLEN-1){1'b0}}, opA < opB};
      AluXor:   result = opA ^ opB;
      AluSrl:   result = opA >> shamt;
      AluSra:   result = $signed(opA) >>> shamt;
      AluOr:    result = opA | opB;
      AluAnd:   result = opA & opB;
      AluPassB: result = opB;
      default:  result = '0;
    endcase
  end

  // ======================================================================
  // Writeback register
  // ======================================================================

  always_ff @(posedge clk) begin
    wb_o.rd   <= dec_i.rd;
    wb_o.data <= result;
    if (rst) begin
      wb_o.valid <= 1'b0;
      illegal_o  <= 1'b0;
    end else begin
      // Results for x0 are dropped here
      wb_o.valid <= dec_i.valid && !dec_i.illegal && (dec_i.rd != '0);
      illegal_o  <= dec_i.valid && dec_i.illegal;   // Single-cycle pulse
    end
  end

  // PASSB only makes sense with the immediate as operand B
  passBNeedsImm: assert property (@(posedge clk) disable iff (rst)
    (dec_i.valid && dec_i.aluOp == AluPassB) |-> dec_i.useImm)
    else $error("PASSB item issued without immediate operand");

endmodule

`default_nettype wire

//--- verilog/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvCore_cfg.svh"

module instrDecoder (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   instrValid_i,
  input  logic [`XLEN-1:0]       instr_i,
  input  logic [`XLEN-1:0]       rs1Data_i,
  input  logic [`XLEN-1:0]       rs2Data_i,
  output logic [`REG_ADDR_W-1:0] rs1Addr_o,
  output logic [`REG_ADDR_W-1:0] rs2Addr_o,
  output rvPkg::decodedT         dec_o
);
  import rvPkg::*;

  logic [2:0]       funct3;
  logic [6:0]       funct7;
  opcodeT           opcode;
  aluOpT            aluOp;
  logic             illegal;
  logic             useImm;
  logic [`XLEN-1:0] imm;
  decodedT          decNext;

  assign funct3    = instr_i[14:12];
  assign funct7    = instr_i[31:25];
  assign opcode    = opcodeT'(instr_i[6:0]);
  assign rs1Addr_o = instr_i[19:15];   // Register file reads same cycle
  assign rs2Addr_o = instr_i[24:20];

  // ======================================================================
  // Opcode and funct decode, immediate generation
  // ======================================================================

  always_comb begin
    aluOp   = AluAdd;
    illegal = 1'b0;
    useImm  = 1'b0;
    imm     = {{20{instr_i[31]}}, instr_i[31:20]};   // I-type by default
    case (opcode)
      OpcOp: begin
        case ({funct7, funct3})
          {`FUNCT7_BASE, 3'b000}: aluOp = AluAdd;
          {`FUNCT7_ALT,  3'b000}: aluOp = AluSub;
          {`FUNCT7_BASE, 3'b001}: aluOp = AluSll;
          {`FUNCT7_BASE, 3'b010}: aluOp = AluSlt;
          {`FUNCT7_BASE, 3'b011}: aluOp = AluSltu;
          {`FUNCT7_BASE, 3'b100}: aluOp = AluXor;
          {`FUNCT7_BASE, 3'b101}: aluOp = AluSrl;
          {`FUNCT7_ALT,  3'b101}: aluOp = AluSra;
          {`FUNCT7_BASE, 3'b110}: aluOp = AluOr;
          {`FUNCT7_BASE, 3'b111}: aluOp = AluAnd;
          default:                illegal = 1'b1;
        endcase
      end
      OpcOpImm: begin
        useImm = 1'b1;
        case (funct3)
          3'b000: aluOp = AluAdd;
          3'b010: aluOp = AluSlt;
          3'b011: aluOp = AluSltu;
          3'b100: aluOp = AluXor;
          3'b110: aluOp = AluOr;
          3'b111: aluOp = AluAnd;
          3'b001: begin
            aluOp   = AluSll;
            illegal = (funct7 != `FUNCT7_BASE);
          end
          default: begin   // 3'b101, SRLI or SRAI
            aluOp   = (funct7 == `FUNCT7_ALT) ? AluSra : AluSrl;
            illegal = (funct7 != `FUNCT7_BASE) && (funct7 != `FUNCT7_ALT);
          end
        endcase
      end
      OpcLui: begin
        aluOp  = AluPassB;
        useImm = 1'b1;
        imm    = {instr_i[31:12], 12'b0};   // U-type
      end
      default: illegal = 1'b1;   // Branches, loads, anything else
    endcase
  end

  always_comb begin
    decNext.valid   = instrValid_i;
    decNext.illegal = illegal;
    decNext.aluOp   = aluOp;
    decNext.useImm  = useImm;
    decNext.rs1     = rs1Addr_o;
    decNext.rs2     = rs2Addr_o;
    decNext.rd      = instr_i[11:7];
    decNext.rs1Val  = rs1Data_i;
    decNext.rs2Val  = rs2Data_i;
    decNext.imm     = imm;
  end

  // Decode register, only valid is cleared
  always_ff @(posedge clk) begin
    dec_o <= decNext;
    if (rst) begin
      dec_o.valid <= 1'b0;
    end
  end

  // x0 operands come back from the register file as zero
  x0ReadsZero: assert property (@(posedge clk) disable iff (rst)
    instrValid_i |-> ((rs1Addr_o != '0 || rs1Data_i == '0) &&
                      (rs2Addr_o != '0 || rs2Data_i == '0)))
    else $error("Nonzero operand value read from x0");

endmodule

`default_nettype wire

//--- verilog/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvCore_cfg.svh"

module registerFile (
  input  logic                   clk,
  input  logic                   rst,
  input  rvPkg::wbT              wb_i,
  input  logic [`REG_ADDR_W-1:0] rs1Addr_i,
  input  logic [`REG_ADDR_W-1:0] rs2Addr_i,
  output logic [`XLEN-1:0]       rs1Data_o,
  output logic [`XLEN-1:0]       rs2Data_o
);

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:`REG_COUNT-1];
  logic             wbHit1;
  logic             wbHit2;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.valid && wb_i.rd != '0) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // Same-cycle write shows up on the read port
  assign wbHit1 = wb_i.valid && (wb_i.rd == rs1Addr_i);
  assign wbHit2 = wb_i.valid && (wb_i.rd == rs2Addr_i);

  assign rs1Data_o = (rs1Addr_i == '0) ? '0 :
                     wbHit1            ? wb_i.data : regs[rs1Addr_i];
  assign rs2Data_o = (rs2Addr_i == '0) ? '0 :
                     wbHit2            ? wb_i.data : regs[rs2Addr_i];

  // Execute stage is expected to drop rd == 0 results
  noWriteToZero: assert property (@(posedge clk) disable iff (rst)
    wb_i.valid |-> (wb_i.rd != '0))
    else $error("Writeback issued to x0");

endmodule

`default_nettype wire

//--- verilog/rvCore.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvCore_cfg.svh"

module rvCore (
  input  logic             clk,
  input  logic             rst,
  input  logic             instrValid_i,
  input  logic [`XLEN-1:0] instr_i,
  output rvPkg::wbT        wb_o,
  output logic             illegal_o
);
  import rvPkg::*;

  logic [`REG_ADDR_W-1:0] rs1Addr;
  logic [`REG_ADDR_W-1:0] rs2Addr;
  logic [`XLEN-1:0]       rs1Data;
  logic [`XLEN-1:0]       rs2Data;
  decodedT                dec;

  // Decode and register read
  instrDecoder decoder (
    .clk          (clk),
    .rst          (rst),
    .instrValid_i (instrValid_i),
    .instr_i      (instr_i),
    .rs1Data_i    (rs1Data),
    .rs2Data_i    (rs2Data),
    .rs1Addr_o    (rs1Addr),
    .rs2Addr_o    (rs2Addr),
    .dec_o        (dec)
  );

  registerFile regFile (
    .clk       (clk),
    .rst       (rst),
    .wb_i      (wb_o),   // Writeback port fed from execute register
    .rs1Addr_i (rs1Addr),
    .rs2Addr_i (rs2Addr),
    .rs1Data_o (rs1Data),
    .rs2Data_o (rs2Data)
  );

  // Execute
  aluStage alu (
    .clk       (clk),
    .rst       (rst),
    .dec_i     (dec),
    .wb_o      (wb_o),
    .illegal_o (illegal_o)
  );

endmodule

`default_nettype wire

//--- verilog/rvPkg.sv
`default_nettype none

`include "rvCore_cfg.svh"

package rvPkg;

  // ======================================================================
  // Opcode and ALU operation encodings
  // ======================================================================

  // Only the major opcodes this core executes
  typedef enum logic [6:0] {
    OpcOp    = `OPC_OP,
    OpcOpImm = `OPC_OP_IMM,
    OpcLui   = `OPC_LUI
  } opcodeT;

  typedef enum logic [3:0] {
    AluAdd,
    AluSub,
    AluSll,
    AluSlt,
    AluSltu,
    AluXor,
    AluSrl,
    AluSra,
    AluOr,
    AluAnd,
    AluPassB   // LUI, second operand straight through
  } aluOpT;

  // ======================================================================
  // Pipeline bundles
  // ======================================================================

  // Decode to execute
  typedef struct packed {
    logic                   valid;
    logic                   illegal;
    aluOpT                  aluOp;
    logic                   useImm;   // Operand B from imm, not rs2
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       rs1Val;
    logic [`XLEN-1:0]       rs2Val;
    logic [`XLEN-1:0]       imm;
  } decodedT;

  // Execute result headed for the register file
  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } wbT;

endpackage

`default_nettype wire
